//--- src.f
design/bpredPkg.sv
design/dirPredictor.sv
design/btbPredictor.sv
design/rasPredictor.sv
design/predCheck.sv
design/bpred.sv
dv/bpredTb.sv

//--- run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f src.f --top-module bpredTb -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "Something failed" >> sim.log

cat build.log sim.log
grep -q "Something failed" sim.log && { echo "RESULT: FAIL"; exit 1; } \
  || { echo "RESULT: PASS"; exit 0; }

//--- dv/bpredTb.sv
`timescale 1ns/100ps

module bpredTb;

  import bpredPkg::*;

  localparam int watchdogCycles = 20000;
  localparam logic [xlen-1:0] idlePc = '0;

  logic            clk;
  logic            rstN;
  logic            stallF;
  logic            stallD;
  logic            stallE;
  logic            flushD;
  logic            flushE;
  logic [xlen-1:0] pcNextF;
  logic [xlen-1:0] pcD;
  logic [xlen-1:0] predPcF;
  logic            selPredF;
  logic            predWrongE;
  execInfoT        exec;

  // Reference model of the three structures
  ctrStateT        ctrModel  [dirEntries];
  logic            btbValid  [btbEntries];
  instrClassT      btbClass  [btbEntries];
  logic [xlen-1:0] btbTarget [btbEntries];
  logic [xlen-1:0] rasModel  [rasDepth];
  int              rasTop;
  // Counter the fetched instruction carries to execute
  ctrStateT        carried;

  bpred dut (
    .clk(clk),
    .rstN(rstN),
    .stallF(stallF),
    .stallD(stallD),
    .stallE(stallE),
    .flushD(flushD),
    .flushE(flushE),
    .pcNextF(pcNextF),
    .predPcF(predPcF),
    .selPredF(selPredF),
    .pcD(pcD),
    .exec(exec),
    .predWrongE(predWrongE)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  // No class in execute means nothing to mispredict
  noWrongWithoutClass: assert property (@(posedge clk) disable iff (!rstN)
      (exec.instrClass == '0) |-> !predWrongE)
    else begin
      $display("error t=%0t predWrongE got 1 expected 0 with no class in execute", $time);
      $display("Something failed");
      $fatal(1, "concurrent check");
    end

  task automatic checkVal(input string name, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] exp);
    assert (got === exp) else begin
      $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Something failed");
      $fatal(1, "value check");
    end
  endtask

  function automatic int idxOf(input logic [xlen-1:0] pc);
    return int'(pc[dirIndexBits+1:2]);
  endfunction

  // One step of a two-bit counter toward the resolved direction
  function automatic ctrStateT stepCtr(input ctrStateT s, input logic taken);
    if (taken) begin
      return (s == strongTaken) ? strongTaken : ctrStateT'(s + 2'd1);
    end
    return (s == strongNotTaken) ? strongNotTaken : ctrStateT'(s - 2'd1);
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Lookup of pc checked in its fetch cycle
  task automatic fetch(input logic [xlen-1:0] pc, input logic flushNext);
    int         i;
    instrClassT c;
    logic       expSel;
    i = idxOf(pc);
    @(posedge clk);
    pcNextF <= pc;
    @(posedge clk);
    pcNextF <= idlePc;
    flushD  <= flushNext;
    @(negedge clk);
    c = btbClass[i];
    expSel = c.ret | ((c.jump | c.jumpReg) & btbValid[i])
           | (c.branch & btbValid[i] & ctrModel[i][1]);
    checkVal("selPredF", selPredF, expSel);
    if (c.ret) begin
      checkVal("predPcF", predPcF, rasModel[rasTop]);
      rasTop = (rasTop + rasDepth - 1) % rasDepth;
    end else if (expSel) begin
      checkVal("predPcF", predPcF, btbTarget[i]);
    end
    carried = flushNext ? strongNotTaken : ctrModel[i];
  endtask

  // Instruction just fetched moves through decode into execute
  task automatic execute(input instrClassT cls, input logic taken, input logic [xlen-1:0] pc,
                         input logic [xlen-1:0] target, input logic [xlen-1:0] pcDVal);
    execInfoT   info;
    logic       expWrong;
    int         i;
    info.pcSrc      = taken;
    info.instrClass = cls;
    info.pc         = pc;
    info.target     = target;
    info.link       = pc + 32'd4;
    i = idxOf(pc);
    @(posedge clk);
    flushD <= 1'b0;
    @(posedge clk);
    exec <= info;
    pcD  <= pcDVal;
    @(negedge clk);
    expWrong = (cls != '0) && ((cls.branch && (carried[1] != taken))
             || (taken ? (pcDVal != target) : (pcDVal != info.link)));
    checkVal("predWrongE", predWrongE, expWrong);
    @(posedge clk);
    exec <= '0;
    // Training lands at this edge
    if (cls.branch) ctrModel[i] = stepCtr(carried, taken);
    if (cls.branch | cls.jump | cls.jumpReg) begin
      btbValid[i]  = 1'b1;
      btbClass[i]  = cls;
      btbTarget[i] = target;
    end
    if (cls.jump) begin
      rasTop = (rasTop + 1) % rasDepth;
      rasModel[rasTop] = info.link;
    end
  endtask

  task automatic branchStep(input logic [xlen-1:0] pc, input logic [xlen-1:0] target,
                            input logic taken);
    fetch(pc, 1'b0);
    execute(4'b0001, taken, pc, target, taken ? target : pc + 32'd4);
  endtask

  initial begin
    int              flips;
    int              sel;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] tgt;
    logic [xlen-1:0] pcDVal;
    instrClassT      cls;
    logic            taken;
    void'($urandom(32'hd3fa_1bc5));
    rstN = 1'b0;
    {stallF, stallD, stallE, flushD, flushE} = '0;
    pcNextF = idlePc;
    pcD = '0;
    exec = '0;
    rasTop = 0;
    for (int k = 0; k < dirEntries; k++) begin
      ctrModel[k] = weakNotTaken;
      btbValid[k] = 1'b0;
      btbClass[k] = '0;
      btbTarget[k] = '0;
    end
    for (int k = 0; k < rasDepth; k++) rasModel[k] = '0;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkVal("selPredF", selPredF, 1'b0);
    checkVal("predWrongE", predWrongE, 1'b0);
    fetch(32'h100, 1'b0);

    // Branch training and counter saturation
    branchStep(32'h200, 32'h3000, 1'b1);
    fetch(32'h200, 1'b0);
    checkVal("selPredF", selPredF, 1'b1);
    execute(4'b0001, 1'b0, 32'h200, 32'h3000, 32'h3000);
    fetch(32'h200, 1'b0);
    checkVal("selPredF", selPredF, 1'b0);
    execute(4'b0000, 1'b0, 32'h200, 32'h3000, 32'h204);
    repeat (3) branchStep(32'h200, 32'h3000, 1'b1);
    flips = 0;
    sel = 1;
    while (sel == 1 && flips < 8) begin
      fetch(32'h200, 1'b0);
      sel = selPredF;
      if (sel == 1) begin
        execute(4'b0001, 1'b0, 32'h200, 32'h3000, 32'h3000);
        flips++;
      end
    end
    checkVal("flips to not taken", flips, 2);

    // Jump selected with a strongly not taken counter
    repeat (2) branchStep(32'h440, 32'h5000, 1'b0);
    fetch(32'h440, 1'b0);
    execute(4'b0010, 1'b1, 32'h440, 32'h5000, 32'h444);
    fetch(32'h440, 1'b0);
    checkVal("selPredF", selPredF, 1'b1);
    checkVal("predPcF", predPcF, 32'h5000);

    // Random mix against the model
    for (int n = 0; n < 40; n++) begin
      pc = {$urandom} & 32'hffff_fffc;
      if (pc[dirIndexBits+1:2] == '0) pc[2] = 1'b1;
      tgt = {$urandom} & 32'hffff_fffc;
      case ($urandom % 4)
        0: cls = 4'b0000;
        1: cls = 4'b0001;
        2: cls = 4'b0010;
        default: cls = 4'b0100;
      endcase
      taken = 1'($urandom % 2);
      case ($urandom % 3)
        0: pcDVal = tgt;
        1: pcDVal = pc + 32'd4;
        default: pcDVal = {$urandom};
      endcase
      fetch(pc, 1'b0);
      execute(cls, taken, pc, tgt, pcDVal);
    end

    // Calls push links and trained returns pop them
    for (int k = 0; k < 3; k++) begin
      pc = 32'h604 + 32'(k * 16);
      fetch(pc, 1'b0);
      execute(4'b0010, 1'b1, pc, 32'h9000, 32'h9000);
    end
    // A return resolves as an indirect jump
    for (int k = 0; k < 3; k++) begin
      pc = 32'h704 + 32'(k * 16);
      fetch(pc, 1'b0);
      execute(4'b1100, 1'b1, pc, 32'h9100, 32'h9100);
    end
    for (int k = 0; k < 3; k++) begin
      fetch(32'h704 + 32'(k * 16), 1'b0);
      checkVal("predPcF", predPcF, 32'h628 - 32'(k * 16));
    end

    // Flush in decode drops the carried taken counter
    repeat (2) branchStep(32'h200, 32'h3000, 1'b1);
    fetch(32'h200, 1'b1);
    checkVal("selPredF", selPredF, 1'b1);
    execute(4'b0001, 1'b0, 32'h200, 32'h3000, 32'h204);

    // Stalled fetch keeps its lookup
    repeat (2) branchStep(32'h200, 32'h3000, 1'b1);
    @(posedge clk);
    pcNextF <= 32'h200;
    @(posedge clk);
    pcNextF <= 32'h100;
    stallF  <= 1'b1;
    @(negedge clk);
    checkVal("selPredF", selPredF, 1'b1);
    checkVal("predPcF", predPcF, 32'h3000);
    @(posedge clk);
    stallF <= 1'b0;
    @(negedge clk);
    checkVal("selPredF", selPredF, 1'b1);
    checkVal("predPcF", predPcF, 32'h3000);
    @(posedge clk);

    $display("Everything OK");
    $finish;
  end

  // Watchdog bounding the whole run
  initial begin
    int cycles;
    for (cycles = 0; cycles < watchdogCycles; cycles++) begin
      @(posedge clk);
    end
    $display("timeout: the run did not finish within %0d cycles", watchdogCycles);
    $display("Something failed");
    $fatal(1, "timeout");
  end

endmodule

//--- design/bpred.sv
`timescale 1ns/100ps

module bpred (
  input  logic                      clk,
  input  logic                      rstN,
  // Pipeline control levels
  input  logic                      stallF,
  input  logic                      stallD,
  input  logic                      stallE,
  input  logic                      flushD,
  input  logic                      flushE,
  // Fetch
  input  logic [bpredPkg::xlen-1:0] pcNextF,
  output logic [bpredPkg::xlen-1:0] predPcF,
  output logic                      selPredF,
  // Execute
  input  logic [bpredPkg::xlen-1:0] pcD,
  input  bpredPkg::execInfoT        exec,
  output logic                      predWrongE
);

  import bpredPkg::*;

  // Fetch stage lookups
  ctrStateT         ctrF;
  btbEntryT         btbEntryF;
  logic [xlen-1:0]  rasTopF;
  logic             rasPop;

  // Prediction as it moves down the pipe
  predStageT        predF;
  predStageT        predD;
  predStageT        predE;

  // Execute stage training
  ctrStateT         nextCtrE;
  logic             btbUpdateE;

  ////////////////////////////////////////
  // Fetch selection
  ////////////////////////////////////////

  // Returns trust the stack without a valid bit
  // Direct and indirect jumps go whenever the buffer knows them
  // Branches also need a taken counter
  assign selPredF = btbEntryF.instrClass.ret
                  | ((btbEntryF.instrClass.jumpReg | btbEntryF.instrClass.jump)
                     & btbEntryF.valid)
                  | (btbEntryF.instrClass.branch & btbEntryF.valid & ctrF[1]);

  assign predPcF = btbEntryF.instrClass.ret ? rasTopF : btbEntryF.target;

  // Pop when the ret actually leaves fetch
  assign rasPop = btbEntryF.instrClass.ret & ~stallF;

  ////////////////////////////////////////
  // F to D to E
  ////////////////////////////////////////

  assign predF.ctr        = ctrF;
  assign predF.instrClass = btbEntryF.instrClass;

  // Flush beats stall in both stages
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      predD <= '0;
      predE <= '0;
    end else begin
      if (flushD) begin
        predD <= '0;
      end else if (!stallD) begin
        predD <= predF;
      end
      if (flushE) begin
        predE <= '0;
      end else if (!stallE) begin
        predE <= predD;
      end
    end
  end

  // Branch, jump and indirect jump all fill the buffer
  assign btbUpdateE = exec.instrClass.branch | exec.instrClass.jump
                    | exec.instrClass.jumpReg;

  ////////////////////////////////////////
  // Predictor structures
  ////////////////////////////////////////

  dirPredictor dirPred (
    .clk        (clk),
    .rstN       (rstN),
    .stallF     (stallF),
    .lookupPc   (pcNextF),
    .prediction (ctrF),
    .updateEn   (exec.instrClass.branch),
    .updatePc   (exec.pc),
    .updateState(nextCtrE)
  );

  btbPredictor btb (
    .clk         (clk),
    .rstN        (rstN),
    .stallF      (stallF),
    .lookupPc    (pcNextF),
    .entry       (btbEntryF),
    .updateEn    (btbUpdateE),
    .updatePc    (exec.pc),
    .updateTarget(exec.target),
    .updateClass (exec.instrClass)
  );

  // Calls push their link
  // No repair after a flush
  rasPredictor ras (
    .clk   (clk),
    .rstN  (rstN),
    .pop   (rasPop),
    .popPc (rasTopF),
    .push  (exec.instrClass.jump),
    .pushPc(exec.link)
  );

  // Checks against the counter that fetch actually used
  predCheck check (
    .exec     (exec),
    .pcD      (pcD),
    .predState(predE.ctr),
    .predWrong(predWrongE),
    .nextState(nextCtrE)
  );

endmodule

//--- design/predCheck.sv
`timescale 1ns/100ps

module predCheck (
  input  bpredPkg::execInfoT        exec,
  input  logic [bpredPkg::xlen-1:0] pcD,
  input  bpredPkg::ctrStateT        predState,
  output logic                      predWrong,
  output bpredPkg::ctrStateT        nextState
);

  import bpredPkg::*;

  // Individual failure reasons
  logic dirWrong;
  logic targetWrong;
  logic fallThroughWrong;
  logic pcWrong;

  ////////////////////////////////////////
  // Misprediction
  ////////////////////////////////////////

  // Only conditional branches have a direction to get wrong
  assign dirWrong = exec.instrClass.branch & (predState[1] ^ exec.pcSrc);

  // pcD is what fetch actually went to next
  assign targetWrong      = pcD != exec.target;
  assign fallThroughWrong = pcD != exec.link;

  // Compare against the path really taken
  assign pcWrong = exec.pcSrc ? targetWrong : fallThroughWrong;

  // Non-control instructions never mispredict
  assign predWrong = (|exec.instrClass) & (dirWrong | pcWrong);

  ////////////////////////////////////////
  // Counter training
  ////////////////////////////////////////

  // Step one state toward the resolved direction
  // Saturates at both ends
  always_comb begin
    case (predState)
      strongNotTaken: begin
        nextState = exec.pcSrc ? weakNotTaken : strongNotTaken;
      end
      weakNotTaken: begin
        nextState = exec.pcSrc ? weakTaken : strongNotTaken;
      end
      weakTaken: begin
        nextState = exec.pcSrc ? strongTaken : weakNotTaken;
      end
      default: begin
        nextState = exec.pcSrc ? strongTaken : weakTaken;
      end
    endcase
  end

endmodule

//--- design/rasPredictor.sv
`timescale 1ns/100ps

module rasPredictor (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      pop,
  output logic [bpredPkg::xlen-1:0] popPc,
  input  logic                      push,
  input  logic [bpredPkg::xlen-1:0] pushPc
);

  import bpredPkg::*;

  // Return addresses
  logic [xlen-1:0] stack [rasDepth];

  // Top of stack and its two neighbours
  logic [rasPtrBits-1:0] top;
  logic [rasPtrBits-1:0] topInc;
  logic [rasPtrBits-1:0] topDec;

  ////////////////////////////////////////
  // Pointer
  ////////////////////////////////////////

  // Pointer wraps modulo depth
  // Oldest entry gets overwritten
  assign topInc = (top == rasPtrBits'(rasDepth - 1)) ? '0 : top + 1'b1;
  assign topDec = (top == '0) ? rasPtrBits'(rasDepth - 1) : top - 1'b1;

  ////////////////////////////////////////
  // Push and pop
  ////////////////////////////////////////

  // Empty stack reads zero
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      top <= '0;
      for (int i = 0; i < rasDepth; i++) begin
        stack[i] <= '0;
      end
    end else begin
      case ({push, pop})
        // Call from execute
        2'b10: begin
          top         <= topInc;
          stack[topInc] <= pushPc;
        end
        // Return seen in fetch
        2'b01: begin
          top <= topDec;
        end
        // Pop consumed the old top and push takes its slot
        2'b11: begin
          stack[top] <= pushPc;
        end
        default: begin
        end
      endcase
    end
  end

  // Current top is always visible to fetch
  assign popPc = stack[top];

endmodule

//--- design/btbPredictor.sv
`timescale 1ns/100ps

module btbPredictor (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      stallF,
  input  logic [bpredPkg::xlen-1:0] lookupPc,
  output bpredPkg::btbEntryT        entry,
  input  logic                      updateEn,
  input  logic [bpredPkg::xlen-1:0] updatePc,
  input  logic [bpredPkg::xlen-1:0] updateTarget,
  input  bpredPkg::instrClassT      updateClass
);

  import bpredPkg::*;

  // Aliasing PCs share an entry since there are no tags
  logic             validMem  [btbEntries];
  instrClassT       classMem  [btbEntries];
  logic [xlen-1:0]  targetMem [btbEntries];

  // Sampled fetch index
  logic [btbIndexBits-1:0] lookupIdx;
  // Index of the executing instruction
  logic [btbIndexBits-1:0] updateIdx;

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  // Same timing as the direction table
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lookupIdx <= '0;
    end else if (!stallF) begin
      lookupIdx <= lookupPc[btbIndexBits+1:2];
    end
  end

  // Entry fields for the fetch cycle
  assign entry.valid      = validMem[lookupIdx];
  assign entry.instrClass = classMem[lookupIdx];
  assign entry.target     = targetMem[lookupIdx];

  ////////////////////////////////////////
  // Fill
  ////////////////////////////////////////

  assign updateIdx = updatePc[btbIndexBits+1:2];

  // No entry is valid and no class is set until the first fill
  // A zero class keeps fetch from seeing a ret
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < btbEntries; i++) begin
        validMem[i] <= 1'b0;
        classMem[i] <= '0;
      end
    end else if (updateEn) begin
      validMem[updateIdx] <= 1'b1;
      classMem[updateIdx] <= updateClass;
    end
  end

  // Target written alongside valid and class
  always_ff @(posedge clk) begin
    if (updateEn) begin
      targetMem[updateIdx] <= updateTarget;
    end
  end

  // Every executed branch or jump refills its slot
  // Most recent target wins for indirect jumps

endmodule

//--- design/dirPredictor.sv
`timescale 1ns/100ps

module dirPredictor (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      stallF,
  input  logic [bpredPkg::xlen-1:0] lookupPc,
  output bpredPkg::ctrStateT        prediction,
  input  logic                      updateEn,
  input  logic [bpredPkg::xlen-1:0] updatePc,
  input  bpredPkg::ctrStateT        updateState
);

  import bpredPkg::*;

  // Counter array with one entry per index
  ctrStateT ctrTable [dirEntries];

  // Index sampled at the fetch edge
  logic [dirIndexBits-1:0] lookupIdx;
  // Index of the instruction in execute
  logic [dirIndexBits-1:0] updateIdx;

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  // Word aligned PCs leave bits 1:0 without information
  // Index holds while fetch is stalled
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lookupIdx <= '0;
    end else if (!stallF) begin
      lookupIdx <= lookupPc[dirIndexBits+1:2];
    end
  end

  // Counter shows during the fetch cycle
  assign prediction = ctrTable[lookupIdx];

  ////////////////////////////////////////
  // Update
  ////////////////////////////////////////

  assign updateIdx = updatePc[dirIndexBits+1:2];

  // Every counter starts weakly not taken
  // Write lands at the edge closing execute
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < dirEntries; i++) begin
        ctrTable[i] <= weakNotTaken;
      end
    end else if (updateEn) begin
      ctrTable[updateIdx] <= updateState;
    end
  end

  // No bypass from a same-cycle update to the lookup
  // A trained counter is seen from the next sampled index on

endmodule

//--- design/bpredPkg.sv
package bpredPkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Address width of the pipeline
  localparam int xlen = 32;

  // Direction table indexed from PC bit 2 upward
  localparam int dirIndexBits = 8;
  localparam int dirEntries = 1 << dirIndexBits;

  // Target buffer uses the same indexing as the direction table
  localparam int btbIndexBits = 8;
  localparam int btbEntries = 1 << btbIndexBits;

  // Return stack
  localparam int rasDepth = 8;
  localparam int rasPtrBits = $clog2(rasDepth);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Two-bit saturating counter
  // Upper bit gives the predicted direction
  typedef enum logic [1:0] {
    strongNotTaken = 2'd0,
    weakNotTaken   = 2'd1,
    weakTaken      = 2'd2,
    strongTaken    = 2'd3
  } ctrStateT;

  // One-hot class
  // All zero means not a control instruction
  typedef struct packed {
    logic ret;
    logic jumpReg;
    logic jump;
    logic branch;
  } instrClassT;

  // Resolved control flow reported by execute
  typedef struct packed {
    logic             pcSrc;
    instrClassT       instrClass;
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  target;
    logic [xlen-1:0]  link;
  } execInfoT;

  // One target buffer entry
  typedef struct packed {
    logic             valid;
    instrClassT       instrClass;
    logic [xlen-1:0]  target;
  } btbEntryT;

  // Prediction carried down the pipe with its instruction
  typedef struct packed {
    ctrStateT         ctr;
    instrClassT       instrClass;
  } predStageT;

endpackage
